/* hw/ex_config.svh */
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

////////////////////
// datapath widths
////////////////////

// operand and result width
`define XLEN 32

// destination tag carried beside each multiply
`define TAG_BITS 6

////////////////////
// pipeline shape
////////////////////

// number of partial-product stages
// 1, 2, 4 or 8 all divide the double-width word evenly
`define NUM_STAGE 4

// multiplier bits consumed in each stage
`define NUM_BITS ((2 * `XLEN) / `NUM_STAGE)

`endif

/* hw/isa_pkg.sv */
`include "ex_config.svh"

package isa_pkg;

	////////////////////
	// multiply functions
	////////////////////

	// encoding follows funct3[1:0] of the M extension
	typedef enum logic [1:0] {
		MUL    = 2'b00, // low half, signed x signed
		MULH   = 2'b01, // high half, signed x signed
		MULHSU = 2'b10, // high half, signed x unsigned
		MULHU  = 2'b11  // high half, unsigned x unsigned
	} mult_func_t;

	// everything except MUL returns the upper word
	function automatic logic is_high_half(input mult_func_t func);
		logic high;
		case (func)
			MUL:     high = 1'b0;
			MULH:    high = 1'b1;
			MULHSU:  high = 1'b1;
			MULHU:   high = 1'b1;
			default: high = 1'b0;
		endcase
		return high;
	endfunction

endpackage

/* hw/mult_operand_prep.sv */
`include "ex_config.svh"

// decodes signedness from the function code and
// widens both operands so a plain unsigned multiply
// of the double-width words gives the right product
module mult_operand_prep (
	input  isa_pkg::mult_func_t   func,
	input  mult_pipe_pkg::word_t  mcand,
	input  mult_pipe_pkg::word_t  mplier,
	output mult_pipe_pkg::dword_t mcand_ext,
	output mult_pipe_pkg::dword_t mplier_ext
);
	import isa_pkg::*;

	logic mcand_signed;
	logic mplier_signed;
	logic mcand_fill;
	logic mplier_fill;

	////////////////////
	// sign decode
	////////////////////

	always_comb begin
		case (func)
			MUL: begin
				mcand_signed  = 1'b1;
				mplier_signed = 1'b1;
			end
			MULH: begin
				mcand_signed  = 1'b1;
				mplier_signed = 1'b1;
			end
			MULHSU: begin // only rs1 is signed
				mcand_signed  = 1'b1;
				mplier_signed = 1'b0;
			end
			MULHU: begin
				mcand_signed  = 1'b0;
				mplier_signed = 1'b0;
			end
			default: begin
				mcand_signed  = 1'b1;
				mplier_signed = 1'b1;
			end
		endcase
	end

	////////////////////
	// extension
	////////////////////

	assign mcand_fill  = mcand_signed & mcand[`XLEN-1]; // replicated into upper word
	assign mplier_fill = mplier_signed & mplier[`XLEN-1];

	assign mcand_ext  = {{`XLEN{mcand_fill}}, mcand};
	assign mplier_ext = {{`XLEN{mplier_fill}}, mplier};

endmodule

/* hw/mult_pipe_pkg.sv */
`include "ex_config.svh"

package mult_pipe_pkg;

	////////////////////
	// widths
	////////////////////

	// extended operands and partial products are twice the word
	localparam int WORD_BITS  = `XLEN;
	localparam int DWORD_BITS = 2 * `XLEN;

	////////////////////
	// datapath types
	////////////////////

	// operand and result word
	typedef logic [WORD_BITS-1:0] word_t;

	// extended operand, running product
	typedef logic [DWORD_BITS-1:0] dword_t;

	// destination tag
	typedef logic [`TAG_BITS-1:0] tag_t;

endpackage

/* hw/mult_result_select.sv */
`include "ex_config.svh"

// drains the last stage
// picks the product half that the item's own function asks for
// and keeps the outputs at zero between results
module mult_result_select (
	input  logic                  valid_in,
	input  mult_pipe_pkg::dword_t product_in,
	input  mult_pipe_pkg::tag_t   tag_in,
	input  isa_pkg::mult_func_t   func_in,
	output logic                  done,
	output mult_pipe_pkg::word_t  product,
	output mult_pipe_pkg::tag_t   dest_tag_out
);
	import mult_pipe_pkg::*;
	import isa_pkg::*;

	word_t low_half;
	word_t high_half;
	word_t chosen;
	logic  take_high;

	////////////////////
	// half select
	////////////////////

	assign low_half  = product_in[WORD_BITS-1:0];
	assign high_half = product_in[DWORD_BITS-1:WORD_BITS];

	assign take_high = is_high_half(func_in); // MUL is the only low-half op

	always_comb begin
		if (take_high) begin
			chosen = high_half;
		end else begin
			chosen = low_half;
		end
	end

	////////////////////
	// outputs
	////////////////////

	assign done = valid_in; // one pulse per item leaving the chain

	// quiet when nothing completes
	always_comb begin
		if (valid_in) begin
			product      = chosen;
			dest_tag_out = tag_in;
		end else begin
			product      = '0;
			dest_tag_out = '0;
		end
	end

endmodule

/* hw/mult_stage.sv */
`include "ex_config.svh"

// one slice of the multiplier chain
// consumes NUM_BITS of the multiplier and adds that partial
// product into the running sum with one cycle of latency
module mult_stage (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  valid_in,
	input  mult_pipe_pkg::dword_t product_in,
	input  mult_pipe_pkg::dword_t mcand_in,
	input  mult_pipe_pkg::dword_t mplier_in,
	input  mult_pipe_pkg::tag_t   tag_in,
	input  isa_pkg::mult_func_t   func_in,
	output logic                  valid_out,
	output mult_pipe_pkg::dword_t product_out,
	output mult_pipe_pkg::dword_t mcand_out,
	output mult_pipe_pkg::dword_t mplier_out,
	output mult_pipe_pkg::tag_t   tag_out,
	output isa_pkg::mult_func_t   func_out
);
	import mult_pipe_pkg::*;
	import isa_pkg::*;

	dword_t mplier_slice;
	dword_t partial_prod;
	dword_t next_sum;
	dword_t next_mplier;
	dword_t next_mcand;

	////////////////////
	// partial product
	////////////////////

	// low bits of the multiplier, zero extended
	assign mplier_slice = dword_t'(mplier_in[`NUM_BITS-1:0]);

	// wraps at double width, which is all the product needs
	assign partial_prod = mplier_slice * mcand_in;
	assign next_sum     = product_in + partial_prod;

	// line up the operands for the next stage
	assign next_mplier = mplier_in >> `NUM_BITS;
	assign next_mcand  = mcand_in << `NUM_BITS;

	////////////////////
	// registers
	////////////////////

	// running sum and shifted operands
	always_ff @(posedge clock) begin
		product_out <= next_sum;
		mplier_out  <= next_mplier;
		mcand_out   <= next_mcand;
	end

	// control travels with the item so mixed functions can overlap
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_out <= 1'b0;
			tag_out   <= '0;
			func_out  <= MUL;
		end else begin
			valid_out <= valid_in;
			tag_out   <= tag_in;
			func_out  <= func_in;
		end
	end

endmodule

/* hw/pipelined_mult.sv */
`include "ex_config.svh"

// pipelined integer multiplier
// accepts one multiply per clock and returns it NUM_STAGE cycles
// later, in issue order, with its tag and a done pulse
module pipelined_mult (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  isa_pkg::mult_func_t  func,
	input  mult_pipe_pkg::word_t mcand,
	input  mult_pipe_pkg::word_t mplier,
	input  mult_pipe_pkg::tag_t  dest_tag_in,
	output logic                 done,
	output mult_pipe_pkg::word_t product,
	output mult_pipe_pkg::tag_t  dest_tag_out
);
	import mult_pipe_pkg::*;
	import isa_pkg::*;

	// index i feeds stage i and index i+1 holds its output
	logic       valid_w   [`NUM_STAGE+1];
	dword_t     product_w [`NUM_STAGE+1];
	dword_t     mcand_w   [`NUM_STAGE+1];
	dword_t     mplier_w  [`NUM_STAGE+1];
	tag_t       tag_w     [`NUM_STAGE+1];
	mult_func_t func_w    [`NUM_STAGE+1];

	////////////////////
	// operand prep
	////////////////////

	mult_operand_prep prep (
		.func       (func),
		.mcand      (mcand),
		.mplier     (mplier),
		.mcand_ext  (mcand_w[0]),
		.mplier_ext (mplier_w[0])
	);

	// head of the chain
	assign product_w[0] = '0;          // running sum starts empty
	assign valid_w[0]   = start;
	assign tag_w[0]     = dest_tag_in;
	assign func_w[0]    = func;

	////////////////////
	// stage chain
	////////////////////

	genvar i;
	generate
		for (i = 0; i < `NUM_STAGE; i++) begin : stage_gen
			mult_stage stage (
				.clock       (clock),
				.reset       (reset),
				.valid_in    (valid_w[i]),
				.product_in  (product_w[i]),
				.mcand_in    (mcand_w[i]),
				.mplier_in   (mplier_w[i]),
				.tag_in      (tag_w[i]),
				.func_in     (func_w[i]),
				.valid_out   (valid_w[i+1]),
				.product_out (product_w[i+1]),
				.mcand_out   (mcand_w[i+1]),
				.mplier_out  (mplier_w[i+1]),
				.tag_out     (tag_w[i+1]),
				.func_out    (func_w[i+1])
			);
		end
	endgenerate

	////////////////////
	// result select
	////////////////////

	// func here belongs to the item leaving the last stage
	mult_result_select result_sel (
		.valid_in     (valid_w[`NUM_STAGE]),
		.product_in   (product_w[`NUM_STAGE]),
		.tag_in       (tag_w[`NUM_STAGE]),
		.func_in      (func_w[`NUM_STAGE]),
		.done         (done),
		.product      (product),
		.dest_tag_out (dest_tag_out)
	);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the multiplier testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing --timescale 1ns/100ps \
	-f tb.f --top-module tb_pipelined_mult -o sim_tb

# keep going past the first assertion so the testbench can report it
./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* tb.f */
+incdir+hw
hw/isa_pkg.sv
hw/mult_pipe_pkg.sv
hw/mult_operand_prep.sv
hw/mult_stage.sv
hw/mult_result_select.sv
hw/pipelined_mult.sv
test/pipelined_mult_chk.sv
test/tb_pipelined_mult.sv

/* test/pipelined_mult_chk.sv */
`include "ex_config.svh"

// bound into pipelined_mult where it sees only the top-level ports
module pipelined_mult_chk (
	input logic                  clock,
	input logic                  reset,
	input logic                  start,
	input isa_pkg::mult_func_t   func,
	input mult_pipe_pkg::word_t  mcand,
	input mult_pipe_pkg::word_t  mplier,
	input mult_pipe_pkg::tag_t   dest_tag_in,
	input logic                  done,
	input mult_pipe_pkg::word_t  product,
	input mult_pipe_pkg::tag_t   dest_tag_out
);
	timeunit 1ns;
	timeprecision 100ps;

	import isa_pkg::*;
	import mult_pipe_pkg::*;

	localparam int DEPTH = `NUM_STAGE;
	localparam int WIDE  = 2 * `XLEN + 1; // holds a signed x unsigned product

	int               fail_count = 0; // assertion failures so far
	logic [DEPTH-1:0] start_hist;     // starts still in flight, oldest at the top

	// inputs of the items in flight, oldest at the highest index
	mult_func_t func_hist   [DEPTH];
	word_t      mcand_hist  [DEPTH];
	word_t      mplier_hist [DEPTH];
	tag_t       tag_hist    [DEPTH];
	word_t      exp_product; // for the item leaving the pipe now

	////////////////////
	// reference product
	////////////////////

	function automatic word_t expected_product(
		input mult_func_t f,
		input word_t      a,
		input word_t      b
	);
		logic signed [WIDE-1:0] wide_a;
		logic signed [WIDE-1:0] wide_b;
		logic signed [WIDE-1:0] full;
		word_t                  result;
		case (f)
			MUL, MULH: begin
				wide_a = WIDE'($signed(a));
				wide_b = WIDE'($signed(b));
			end
			MULHSU: begin // rs1 signed, rs2 unsigned
				wide_a = WIDE'($signed(a));
				wide_b = WIDE'(b);
			end
			default: begin
				wide_a = WIDE'(a);
				wide_b = WIDE'(b);
			end
		endcase
		full = wide_a * wide_b;
		if (f == MUL) begin
			result = full[`XLEN-1:0];
		end else begin
			result = full[2*`XLEN-1:`XLEN];
		end
		return result;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			start_hist <= '0;
		end else begin
			start_hist <= (start_hist << 1) | DEPTH'(start);
		end
	end

	always_ff @(posedge clock) begin
		func_hist[0]   <= func;
		mcand_hist[0]  <= mcand;
		mplier_hist[0] <= mplier;
		tag_hist[0]    <= dest_tag_in;
		for (int k = 1; k < DEPTH; k++) begin
			func_hist[k]   <= func_hist[k-1];
			mcand_hist[k]  <= mcand_hist[k-1];
			mplier_hist[k] <= mplier_hist[k-1];
			tag_hist[k]    <= tag_hist[k-1];
		end
	end

	assign exp_product = expected_product(func_hist[DEPTH-1], mcand_hist[DEPTH-1],
		mplier_hist[DEPTH-1]);

	////////////////////
	// properties
	////////////////////

	// one done per start exactly DEPTH cycles later
	done_latency: assert property (@(posedge clock) disable iff (reset)
		done == start_hist[DEPTH-1])
		else begin
			fail_count = fail_count + 1;
			$error("CHECK FAILED: done_latency expected %0b actual %0b",
				$sampled(start_hist[DEPTH-1]), $sampled(done));
		end

	product_value: assert property (@(posedge clock) disable iff (reset)
		done |-> product == exp_product)
		else begin
			fail_count = fail_count + 1;
			$error("CHECK FAILED: product_value expected %h actual %h",
				$sampled(exp_product), $sampled(product));
		end

	tag_value: assert property (@(posedge clock) disable iff (reset)
		done |-> dest_tag_out == tag_hist[DEPTH-1])
		else begin
			fail_count = fail_count + 1;
			$error("CHECK FAILED: tag_value expected %0d actual %0d",
				$sampled(tag_hist[DEPTH-1]), $sampled(dest_tag_out));
		end

	// nothing leaves the pipe right after a reset edge
	reset_quiet: assert property (@(posedge clock) $past(reset) |-> !done)
		else begin
			fail_count = fail_count + 1;
			$error("CHECK FAILED: reset_quiet expected done 0 actual %0b", $sampled(done));
		end

	idle_quiet: assert property (@(posedge clock) !done |-> dest_tag_out == '0 && product == '0)
		else begin
			fail_count = fail_count + 1;
			$error("CHECK FAILED: idle_quiet expected product 0 tag 0 actual product %h tag %0d",
				$sampled(product), $sampled(dest_tag_out));
		end

endmodule

bind pipelined_mult pipelined_mult_chk chk (
	.clock        (clock),
	.reset        (reset),
	.start        (start),
	.func         (func),
	.mcand        (mcand),
	.mplier       (mplier),
	.dest_tag_in  (dest_tag_in),
	.done         (done),
	.product      (product),
	.dest_tag_out (dest_tag_out)
);

/* test/tb_pipelined_mult.sv */
`include "ex_config.svh"

module tb_pipelined_mult;
	timeunit 1ns;
	timeprecision 100ps;

	import isa_pkg::*;
	import mult_pipe_pkg::*;

	localparam int LATENCY     = `NUM_STAGE;
	localparam int DRAIN_LIMIT = `NUM_STAGE + 16; // cycles allowed for results still in flight
	localparam int BURST_LEN   = 200;

	logic       clock;
	logic       reset;
	logic       start;
	mult_func_t func;
	word_t      mcand;
	word_t      mplier;
	tag_t       dest_tag_in;
	logic       done;
	word_t      product;
	tag_t       dest_tag_out;

	int   start_count;
	int   done_count;
	tag_t next_tag;

	pipelined_mult UUT (
		.clock        (clock),
		.reset        (reset),
		.start        (start),
		.func         (func),
		.mcand        (mcand),
		.mplier       (mplier),
		.dest_tag_in  (dest_tag_in),
		.done         (done),
		.product      (product),
		.dest_tag_out (dest_tag_out)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// done has settled by the falling edge
	always @(negedge clock) begin
		if (done) begin
			done_count = done_count + 1;
		end
	end

	////////////////////
	// helpers
	////////////////////

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	// lands 10 ns past the next rising edge
	task automatic next_cycle();
		@(posedge clock);
		#10;
		if (UUT.chk.fail_count != 0) begin
			stop_on_failure("an assertion in the bound checker failed");
		end
	endtask

	task automatic issue(input mult_func_t f, input word_t a, input word_t b);
		start       = 1'b1;
		func        = f;
		mcand       = a;
		mplier      = b;
		dest_tag_in = next_tag;
		next_tag    = next_tag + tag_t'(1); // wraps, still unique within the pipe
		start_count = start_count + 1;
		next_cycle();
	endtask

	task automatic idle(input int cycles);
		start  = 1'b0;
		mcand  = '0;
		mplier = '0;
		repeat (cycles) next_cycle();
	endtask

	task automatic check_count(input string test_name, input int expected, input int actual);
		if (actual != expected) begin
			stop_on_failure($sformatf("CHECK FAILED: %s done pulses expected %0d actual %0d",
				test_name, expected, actual));
		end
	endtask

	// wait for every outstanding result, then compare the counts
	task automatic drain(input string test_name);
		int waited;
		waited = 0;
		start  = 1'b0;
		while (done_count < start_count && waited < DRAIN_LIMIT) begin
			next_cycle();
			waited = waited + 1;
		end
		if (done_count < start_count) begin
			stop_on_failure($sformatf("%s: timeout, the expected done never came", test_name));
		end
		idle(2); // a stray extra done would show up here
		check_count(test_name, start_count, done_count);
	endtask

	function automatic word_t random_word();
		return word_t'($urandom());
	endfunction

	function automatic word_t with_top_bit(input word_t w);
		return w | (word_t'(1) << (`XLEN - 1));
	endfunction

	function automatic mult_func_t random_func();
		return mult_func_t'(2'($urandom_range(3, 0)));
	endfunction

	////////////////////
	// stimulus
	////////////////////

	initial begin
		void'($urandom(90));
		reset       = 1'b1;
		start       = 1'b0;
		func        = MUL;
		mcand       = '0;
		mplier      = '0;
		dest_tag_in = '0;
		start_count = 0;
		done_count  = 0;
		next_tag    = '0;

		repeat (3) @(posedge clock);
		#10;
		reset = 1'b0;
		idle(LATENCY); // pipe must stay empty
		check_count("reset_idle", 0, done_count);

		issue(MUL, word_t'(-3), word_t'(7));
		issue(MUL, word_t'(-1), word_t'(-1));
		issue(MUL, with_top_bit('0), word_t'(-1));
		issue(MUL, word_t'(12345), word_t'(-6789));
		repeat (20) issue(MUL, random_word(), random_word());
		drain("mul_signed");

		issue(MULH, word_t'(-1), word_t'(-1));
		issue(MULH, with_top_bit('0), with_top_bit('0));
		issue(MULH, ~with_top_bit('0), ~with_top_bit('0)); // largest positive squared
		issue(MULH, word_t'(-2), word_t'(3));
		repeat (20) issue(MULH, random_word(), random_word());
		drain("mulh_signed");

		issue(MULHSU, word_t'(-1), word_t'(-1));
		issue(MULHU, word_t'(-1), word_t'(-1));
		repeat (20) begin
			issue(MULHSU, with_top_bit(random_word()), with_top_bit(random_word()));
			issue(MULHU, with_top_bit(random_word()), with_top_bit(random_word()));
		end
		drain("mulhsu_mulhu");

		// one item at a time so each done stands alone
		repeat (8) begin
			issue(random_func(), random_word(), random_word());
			drain("isolated_latency");
		end

		repeat (BURST_LEN) issue(random_func(), random_word(), random_word());
		drain("back_to_back");

		if (UUT.chk.fail_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			stop_on_failure("the bound checker reported assertion failures");
		end
	end

endmodule
